/* verilog/cp0_defs.svh */
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// ----------------------------------------
// Widths
// ----------------------------------------

// Data and PC width
`define XLEN 32

// Device request lines
`define IRQ_LINES 8

// Interrupt number, enough for IRQ_LINES
`define CODE_W 3

// Wishbone word address
`define WB_ADR_W 2

// ----------------------------------------
// Register word addresses
// ----------------------------------------

`define REG_STATUS 2'd0
`define REG_CAUSE 2'd1
`define REG_EPC 2'd2
// Address 3 is a hole, reads zero

// ----------------------------------------
// Bit positions
// ----------------------------------------

// STATUS global interrupt enable
`define STATUS_IE_BIT 0

// Base of the 8-bit mask in STATUS
// and of the 8-bit pending field in CAUSE
`define IM_LSB 8

// Base of the interrupt number in CAUSE
`define CODE_LSB 2

`endif

/* verilog/cp0_pkg.sv */
package cp0_pkg;

`include "cp0_defs.svh"

    // ----------------------------------------
    // Wishbone classic slave port
    // ----------------------------------------

    // Master to slave
    typedef struct packed {
        // Cycle and strobe, held until ack
        logic                  cyc;
        logic                  stb;
        // High for a write
        logic                  we;
        // Word address, full words only
        logic [`WB_ADR_W-1:0]  adr;
        // Write data
        logic [`XLEN-1:0]      dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        // One-cycle acknowledge
        logic                  ack;
        // Read data, valid with ack
        logic [`XLEN-1:0]      dat;
    } wb_rsp_t;

    // ----------------------------------------
    // Register block and arbiter
    // ----------------------------------------

    // Enable and mask taken from STATUS
    typedef struct packed {
        logic                  ie;
        logic [`IRQ_LINES-1:0] im;
    } irq_cfg_t;

    // Capture request back to the registers
    typedef struct packed {
        // High for the single iack cycle
        logic                  take;
        // Line being serviced
        logic [`CODE_W-1:0]    code;
    } irq_take_t;

endpackage

/* verilog/irq_arbiter.sv */
`timescale 1ns/1ns

`include "cp0_defs.svh"

module irq_arbiter
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Level-sensitive device lines
    input  logic [`IRQ_LINES-1:0] irq,
    // Enable and mask from STATUS
    input  irq_cfg_t              cfg,
    // Return from the service routine
    input  logic                  eret,
    // Capture request to the registers
    output irq_take_t             take,
    output logic                  iack,
    output logic                  in_isr
);

    // ----------------------------------------
    // Priority pick
    // ----------------------------------------

    logic [`IRQ_LINES-1:0] irq_masked;
    logic [`CODE_W-1:0]    sel_code;

    // Stage 1 holds the sampled request
    logic                  pend_q;
    logic [`CODE_W-1:0]    pend_code_q;

    // Stage 2 holds the take and service state
    logic                  take_next;
    logic                  take_q;
    logic [`CODE_W-1:0]    take_code_q;
    logic                  in_isr_q;

    assign irq_masked = irq & cfg.im;

    // Lowest numbered line wins
    always_comb begin
        sel_code = '0;
        for (int i = `IRQ_LINES - 1; i >= 0; i--) begin
            if (irq_masked[i]) begin
                sel_code = i[`CODE_W-1:0];
            end
        end
    end

    // Line number of the pick
    always_ff @(posedge clk) begin
        pend_code_q <= sel_code;
    end

    // ----------------------------------------
    // Take decision
    // ----------------------------------------

    // Only outside a service routine
    assign take_next = pend_q & ~in_isr_q;

    // Code held for the iack cycle
    always_ff @(posedge clk) begin
        if (take_next) begin
            take_code_q <= pend_code_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q   <= 1'b0;
            take_q   <= 1'b0;
            in_isr_q <= 1'b0;
        end else begin
            pend_q <= cfg.ie & (|irq_masked);
            // Single-cycle pulse as in_isr blocks a repeat
            take_q <= take_next;
            if (take_next) begin
                in_isr_q <= 1'b1;
            end else if (eret) begin
                in_isr_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    assign take.take = take_q;
    assign take.code = take_code_q;

    // Same register as the capture strobe
    assign iack   = take_q;
    assign in_isr = in_isr_q;

endmodule

/* verilog/cp0_regs.sv */
`timescale 1ns/1ns

`include "cp0_defs.svh"

module cp0_regs
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Host bus
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    // Raw device lines, shown in CAUSE
    input  logic [`IRQ_LINES-1:0] irq,
    // Current fetch address for EPC
    input  logic [`XLEN-1:0]      fetch_pc,
    // Capture from the arbiter
    input  irq_take_t             take,
    // Enable and mask to the arbiter
    output irq_cfg_t              cfg
);

    // ----------------------------------------
    // Register state
    // ----------------------------------------

    // STATUS, every bit writable
    logic [`XLEN-1:0]   status_q;
    // EPC, loaded by host or by a take
    logic [`XLEN-1:0]   epc_q;
    // Only stored field of CAUSE
    logic [`CODE_W-1:0] code_q;

    // Bus handshake
    logic               ack_q;
    logic [`XLEN-1:0]   rdat_q;

    // Access decode
    logic               wb_hit;
    logic               wr_en;
    logic               rd_en;
    logic               wr_status;
    logic               wr_cause;
    logic               wr_epc;

    // Read mux and assembled CAUSE
    logic [`XLEN-1:0]   rd_data;
    logic [`XLEN-1:0]   cause_word;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    // New request seen, no ack issued yet
    assign wb_hit = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en  = wb_hit & wb_req.we;
    assign rd_en  = wb_hit & ~wb_req.we;

    // Per-register write strobes
    assign wr_status = wr_en && (wb_req.adr == `REG_STATUS);
    assign wr_cause  = wr_en && (wb_req.adr == `REG_CAUSE);
    assign wr_epc    = wr_en && (wb_req.adr == `REG_EPC);

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    // CAUSE built from live lines plus stored code
    always_comb begin
        cause_word = '0;
        cause_word[`IM_LSB +: `IRQ_LINES] = irq;
        cause_word[`CODE_LSB +: `CODE_W] = code_q;
    end

    always_comb begin
        case (wb_req.adr)
            `REG_STATUS: rd_data = status_q;
            `REG_CAUSE:  rd_data = cause_word;
            `REG_EPC:    rd_data = epc_q;
            // Unused slot
            default:     rd_data = '0;
        endcase
    end

    // Read data sampled at the request edge
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdat_q <= rd_data;
        end
    end

    // ----------------------------------------
    // Control and register updates
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            status_q <= '0;
            epc_q    <= '0;
            code_q   <= '0;
        end else begin
            // Ack one cycle after the request
            ack_q <= wb_hit;

            if (wr_status) begin
                status_q <= wb_req.dat;
            end

            // Capture beats a host write on the same edge
            if (take.take) begin
                epc_q <= fetch_pc;
            end else if (wr_epc) begin
                epc_q <= wb_req.dat;
            end

            // Pending bits are read-only, only the code is stored
            if (take.take) begin
                code_q <= take.code;
            end else if (wr_cause) begin
                code_q <= wb_req.dat[`CODE_LSB +: `CODE_W];
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    // Steering fields for the arbiter
    assign cfg.ie = status_q[`STATUS_IE_BIT];
    assign cfg.im = status_q[`IM_LSB +: `IRQ_LINES];

endmodule

/* verilog/cp0_irq.sv */
`timescale 1ns/1ns

`include "cp0_defs.svh"

module cp0_irq
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Host register access
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    // Device request lines
    input  logic [`IRQ_LINES-1:0] irq,
    // From the core
    input  logic [`XLEN-1:0]      fetch_pc,
    input  logic                  eret,
    // To the core
    output logic                  iack,
    output logic                  in_isr
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------

    // STATUS fields steering the pick
    irq_cfg_t  irq_cfg;
    // Capture strobe and line number
    irq_take_t irq_take;

    // Bus side and register file
    cp0_regs u_cp0_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .irq      (irq),
        .fetch_pc (fetch_pc),
        .take     (irq_take),
        .cfg      (irq_cfg)
    );

    // Priority and service state
    irq_arbiter u_irq_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .irq    (irq),
        .cfg    (irq_cfg),
        .eret   (eret),
        .take   (irq_take),
        .iack   (iack),
        .in_isr (in_isr)
    );

endmodule

/* sim/cp0_irq_props.sv */
`timescale 1ns/1ns

module cp0_irq_props
    import cp0_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp,
    input logic    iack,
    input logic    in_isr
);

    // Ack only for a request seen one cycle earlier
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb in the previous cycle");

    // Single-cycle acknowledge
    iack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        iack |=> !iack)
        else $error("iack held high for two cycles");

    // No new take from inside a service routine
    iack_outside_isr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(iack) |-> !$past(in_isr))
        else $error("iack rose while in_isr was high");

    in_isr_with_iack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_isr) |-> iack)
        else $error("in_isr rose without iack");

endmodule

bind cp0_irq cp0_irq_props u_cp0_irq_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .iack   (iack),
    .in_isr (in_isr)
);

/* sim/tb_checker.sv */
`timescale 1ns/1ns

`include "cp0_defs.svh"

module tb_checker
    import cp0_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // DUT ports under watch
    input  wb_rsp_t              wb_rsp,
    input  logic                 iack,
    input  logic                 in_isr,
    // Current test from the stimulus side
    input  int                   test_num,
    input  logic [3:0]           test_op,
    input  logic                 test_done,
    input  logic                 run_done,
    input  int                   req_count,
    // Expectations
    input  logic                 chk_rd,
    input  logic [`WB_ADR_W-1:0] exp_adr,
    input  logic [`XLEN-1:0]     exp_dat,
    input  logic                 chk_iack,
    input  logic                 chk_isr,
    input  logic                 quiet,
    output int                   fail_count
);

    int   pass_count;
    // Per-test tallies
    int   ack_count;
    int   iack_count;
    logic test_bad;
    logic summary_done;

    function automatic string reg_name(input logic [`WB_ADR_W-1:0] adr);
        case (adr)
            `REG_STATUS: return "status";
            `REG_CAUSE:  return "cause";
            `REG_EPC:    return "epc";
            default:     return "reg3";
        endcase
    endfunction

    function automatic string step_name(input logic [3:0] op);
        case (op)
            4'd1:    return "write";
            4'd2:    return "read";
            4'd3:    return "drive";
            4'd4:    return "eret";
            4'd5:    return "take";
            4'd6:    return "quiet";
            4'd7:    return "in_isr";
            default: return "unknown";
        endcase
    endfunction

    // Sampled on the rising edge, inputs change on the falling one
    always @(posedge clk) begin
        if (!rst_n) begin
            fail_count   = 0;
            pass_count   = 0;
            ack_count    = 0;
            iack_count   = 0;
            test_bad     = 1'b0;
            summary_done = 1'b0;
        end else begin
            // ----------------------------------------
            // Bus responses
            // ----------------------------------------
            if (wb_rsp.ack) begin
                ack_count = ack_count + 1;
                if (chk_rd && wb_rsp.dat !== exp_dat) begin
                    $display("Fail test %0d: %s expected 0x%08h got 0x%08h",
                             test_num, reg_name(exp_adr), exp_dat, wb_rsp.dat);
                    test_bad = 1'b1;
                end
            end

            // ----------------------------------------
            // Interrupt acknowledge
            // ----------------------------------------
            if (iack) begin
                if (quiet) begin
                    $display("test %0d: iack appeared inside the quiet window", test_num);
                    test_bad = 1'b1;
                end
                if (chk_iack) begin
                    iack_count = iack_count + 1;
                end
            end

            // End of test, wrap up and report
            if (test_done) begin
                if (test_op == 4'd0 || test_op > 4'd7) begin
                    $display("test %0d: unknown step code in the data file", test_num);
                    test_bad = 1'b1;
                end
                if (ack_count != req_count) begin
                    $display("test %0d: %0d bus requests but %0d acks, an ack went missing",
                             test_num, req_count, ack_count);
                    test_bad = 1'b1;
                end
                if (chk_iack && iack_count != 1) begin
                    $display("test %0d: expected one iack pulse, saw %0d",
                             test_num, iack_count);
                    test_bad = 1'b1;
                end
                if (chk_isr && in_isr !== exp_dat[0]) begin
                    $display("Fail test %0d: in_isr expected 0x%h got 0x%h",
                             test_num, exp_dat[0], in_isr);
                    test_bad = 1'b1;
                end
                if (test_bad) begin
                    fail_count = fail_count + 1;
                end else begin
                    pass_count = pass_count + 1;
                end
                $display("test %0d %s: %s", test_num, step_name(test_op),
                         test_bad ? "failed" : "passed");
                ack_count  = 0;
                iack_count = 0;
                test_bad   = 1'b0;
            end

            if (run_done && !summary_done) begin
                $display("tests run %0d, passed %0d, failed %0d",
                         pass_count + fail_count, pass_count, fail_count);
                summary_done = 1'b1;
            end
        end
    end

endmodule

/* sim/tb_cp0_irq.sv */
`timescale 1ns/1ns

`include "cp0_defs.svh"

module tb_cp0_irq
    import cp0_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    // Watchdog budget per data line
    localparam int CYCLES_PER_TEST = 40;
    localparam int ACK_LIMIT = 8;
    localparam int IACK_LIMIT = 8;
    // 256 words at four per line
    localparam int MAX_TESTS = 63;

    logic                  clk;
    logic                  rst_n;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [`IRQ_LINES-1:0] irq;
    logic [`XLEN-1:0]      fetch_pc;
    logic                  eret;
    logic                  iack;
    logic                  in_isr;

    // ----------------------------------------
    // Handoff to the checker
    // ----------------------------------------
    int                    test_num;
    logic [3:0]            test_op;
    logic                  test_done;
    logic                  run_done;
    int                    req_count;
    logic                  chk_rd;
    logic [`WB_ADR_W-1:0]  exp_adr;
    logic [`XLEN-1:0]      exp_dat;
    logic                  chk_iack;
    logic                  chk_isr;
    logic                  quiet;
    int                    fail_count;

    // Test steps as op then three arguments
    logic [31:0]           steps [0:255];
    int                    n_tests;
    logic                  loaded;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cp0_irq dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .irq      (irq),
        .fetch_pc (fetch_pc),
        .eret     (eret),
        .iack     (iack),
        .in_isr   (in_isr)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_rsp     (wb_rsp),
        .iack       (iack),
        .in_isr     (in_isr),
        .test_num   (test_num),
        .test_op    (test_op),
        .test_done  (test_done),
        .run_done   (run_done),
        .req_count  (req_count),
        .chk_rd     (chk_rd),
        .exp_adr    (exp_adr),
        .exp_dat    (exp_dat),
        .chk_iack   (chk_iack),
        .chk_isr    (chk_isr),
        .quiet      (quiet),
        .fail_count (fail_count)
    );

    // ----------------------------------------
    // Bus and sideband tasks
    // ----------------------------------------

    // Hold the request until ack and then drop it
    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge clk);
        while (wb_rsp.ack !== 1'b1 && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        // Ack cycle ends at the next rising edge
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [`WB_ADR_W-1:0] adr, input logic [`XLEN-1:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        req_count  = req_count + 1;
        wait_ack();
    endtask

    task automatic bus_read(input logic [`WB_ADR_W-1:0] adr, input logic [`XLEN-1:0] exp);
        chk_rd     = 1'b1;
        exp_adr    = adr;
        exp_dat    = exp;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        req_count  = req_count + 1;
        wait_ack();
    endtask

    // Wait for iack and read back CAUSE and EPC
    task automatic take_check(input logic [`CODE_W-1:0] code, input logic [`XLEN-1:0] pc,
                              input logic [`IRQ_LINES-1:0] pend);
        logic [`XLEN-1:0] cause_exp;
        int               n;
        cause_exp = '0;
        cause_exp[`IM_LSB +: `IRQ_LINES] = pend;
        cause_exp[`CODE_LSB +: `CODE_W] = code;
        chk_iack = 1'b1;
        n = 0;
        while (iack !== 1'b1 && n < IACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        // EPC and code land on the edge after iack
        @(negedge clk);
        bus_read(`REG_CAUSE, cause_exp);
        bus_read(`REG_EPC, pc);
    endtask

    task automatic quiet_window(input logic [31:0] cycles);
        quiet = 1'b1;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic eret_pulse();
        eret = 1'b1;
        @(negedge clk);
        eret = 1'b0;
    endtask

    // One-cycle done strobe and cleared expectations
    task automatic finish_test();
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        chk_rd    = 1'b0;
        chk_iack  = 1'b0;
        chk_isr   = 1'b0;
        quiet     = 1'b0;
        req_count = 0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [7:0]  ix;
        int          t;
        clk       = 1'b0;
        rst_n     = 1'b0;
        wb_req    = '0;
        irq       = '0;
        fetch_pc  = '0;
        eret      = 1'b0;
        test_num  = 0;
        test_op   = '0;
        test_done = 1'b0;
        run_done  = 1'b0;
        req_count = 0;
        chk_rd    = 1'b0;
        exp_adr   = '0;
        exp_dat   = '0;
        chk_iack  = 1'b0;
        chk_isr   = 1'b0;
        quiet     = 1'b0;
        loaded    = 1'b0;
        n_tests   = 0;

        $readmemh("sim/cp0_irq_testdata.txt", steps);
        // Count lines up to the zero end marker
        ix = '0;
        while (steps[ix] != '0 && n_tests < MAX_TESTS) begin
            n_tests++;
            ix = ix + 8'd4;
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        ix = '0;
        for (t = 1; t <= n_tests; t++) begin
            op = steps[ix];
            a  = steps[ix + 8'd1];
            b  = steps[ix + 8'd2];
            c  = steps[ix + 8'd3];
            ix = ix + 8'd4;
            test_num = t;
            // Out of range codes show up as step zero
            test_op  = (op > 32'd15) ? 4'd0 : op[3:0];
            case (op)
                32'd1: bus_write(a[`WB_ADR_W-1:0], b);
                32'd2: bus_read(a[`WB_ADR_W-1:0], b);
                32'd3: begin
                    irq      = a[`IRQ_LINES-1:0];
                    fetch_pc = b;
                end
                32'd4: eret_pulse();
                32'd5: take_check(a[`CODE_W-1:0], b, c[`IRQ_LINES-1:0]);
                32'd6: quiet_window(a);
                32'd7: begin
                    chk_isr = 1'b1;
                    exp_dat = a;
                end
                // Checker flags the unknown step
                default: ;
            endcase
            finish_test();
        end

        run_done = 1'b1;
        @(negedge clk);
        if (fail_count == 0 && n_tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the number of data lines
    initial begin
        wait (loaded === 1'b1);
        #((n_tests + 1) * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired, the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sim/cp0_irq_testdata.txt */
// Columns, hex: step arg_a arg_b arg_c. Steps: 1 write adr data, 2 read adr expect,
// 3 drive irq fetch_pc, 4 eret, 5 take code epc pending, 6 quiet cycles, 7 in_isr, 0 end
7 0 0 0            // in_isr low after reset
6 4 0 0            // no iack after reset
2 0 0 0            // status
2 1 0 0            // cause, irq low
2 2 0 0            // epc
2 3 0 0            // unused slot
1 0 12345600 0     // status readback, ie clear
2 0 12345600 0
1 2 89abcdef 0     // epc readback
2 2 89abcdef 0
1 3 ffffffff 0     // unused slot ignores writes
2 3 0 0
1 0 0000ff00 0     // all unmasked, ie clear
3 24 00001000 0
6 14 0 0
2 1 00002400 0     // pending shows raw lines
1 0 0000db01 0     // ie set, lines 2 and 5 masked
6 14 0 0
2 1 00002400 0
3 0 00400100 0
1 0 0000ff01 0     // enable all
2 0 0000ff01 0
3 2c 00400100 0    // lines 2, 3, 5
5 2 00400100 2c
7 1 0 0
3 2d 00400300 0    // new request inside the routine
6 14 0 0
2 1 00002d08 0
4 0 0 0            // return, line 0 still pending
5 0 00400300 2d
3 0 00400400 0
4 0 0 0
7 0 0 0
6 14 0 0
1 1 ffffffff 0     // only the code field is written
2 1 0000001c 0
0 0 0 0

/* sources.f */
+incdir+verilog
verilog/cp0_pkg.sv
verilog/irq_arbiter.sv
verilog/cp0_regs.sv
verilog/cp0_irq.sv
sim/cp0_irq_props.sv
sim/tb_checker.sv
sim/tb_cp0_irq.sv

/* run.sh */
#!/bin/sh
# Build and run the cp0_irq testbench with Verilator

verilator --binary --timing --assert -f sources.f --top-module tb_cp0_irq -o tb_cp0_irq \
    > build.log 2>&1 \
    && ./obj_dir/tb_cp0_irq > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
